// ==== source/PixelPkg.sv ====
//-------------------------------------------------
// RGB565 colour with an 8-bit texel alpha
// Position sideband is carried raw and never decoded
//-------------------------------------------------
package PixelPkg;

	//-------------------------------------------------
	// Colour and position widths
	//-------------------------------------------------
	localparam int redW   = 5;
	localparam int greenW = 6;
	localparam int blueW  = 5;
	localparam int chanW  = greenW;				// Widest channel sets blend datapath
	localparam int alphaW = 8;
	localparam int posHW  = 11;					// Horizontal position
	localparam int posVW  = 11;					// Vertical position

	//-------------------------------------------------
	// Blend constants
	//-------------------------------------------------
	localparam int blendShift = alphaW;			// Divide by 256
	localparam int blendSumW  = chanW + blendShift;	// 63 * 256 still fits
	localparam logic [blendSumW-1:0] alphaOne = blendSumW'(1 << alphaW);	// Weight 256

	typedef struct packed {
		logic [redW-1:0]   r;
		logic [greenW-1:0] g;
		logic [blueW-1:0]  b;
	} pixelColorT;

	typedef struct packed {
		logic [posHW-1:0] baseH;				// Base horizontal position
		logic [posVW-1:0] baseV;
		logic [posHW-1:0] playerH;				// Player horizontal position
		logic [posVW-1:0] playerV;
	} posT;

	// One beat of the raster stream
	typedef struct packed {
		pixelColorT color;
		logic       valid;						// Pixel strobe
		logic       frame;						// High for whole frame
		posT        pos;
	} pixelStreamT;

	typedef struct packed {
		pixelColorT        color;
		logic [alphaW-1:0] alpha;				// 0 keeps background
	} texelT;

	typedef logic [1:0] playerDirT;				// 0 down, 1 up, 2 right, 3 left

endpackage

// ==== source/BusPkg.sv ====
//-------------------------------------------------
// Write-only texture port, region code in address bits 31:24
//-------------------------------------------------
package BusPkg;

	//-------------------------------------------------
	// Texture RAM geometry
	//-------------------------------------------------
	localparam int bankW    = 2;					// One bank per direction
	localparam int pixIdxW  = 8;					// 256 texels per bank
	localparam int texAdrsW = bankW + pixIdxW;	// 10 bits
	localparam int texDepth = 1 << texAdrsW;		// 1024 texels

	//-------------------------------------------------
	// Address map
	//-------------------------------------------------
	localparam int busAdrsW = 32;
	localparam int regionLo = 24;				// Region code starts here
	localparam logic [busAdrsW-regionLo-1:0] texRegion = 8'h01;

	// One write beat, no response path
	typedef struct packed {
		logic                we;				// Write strobe
		logic [busAdrsW-1:0] adrs;
		PixelPkg::texelT     data;				// Colour plus alpha
	} busWriteT;

endpackage

// ==== source/TextureRam.sv ====
//-------------------------------------------------
// Contents are not cleared by reset, load through the write port
// Read of an address being written returns the old texel
//-------------------------------------------------
`timescale 1ns/1ps

module TextureRam
(
	input  logic                        iCLK,
	// Write side
	input  logic                        we,
	input  logic [BusPkg::texAdrsW-1:0] wAdrs,
	input  PixelPkg::texelT             wData,
	// Read side
	input  logic [BusPkg::texAdrsW-1:0] rAdrs,
	output PixelPkg::texelT             rData		// One clock after rAdrs
);

	//-------------------------------------------------
	// Storage
	//-------------------------------------------------
	// Four direction banks back to back
	// Bank n occupies n*256 up to n*256+255
	PixelPkg::texelT mem [BusPkg::texDepth];

	//-------------------------------------------------
	// Write and registered read
	//-------------------------------------------------
	// Both ports on one clock so the tools map this to a single BRAM
	// Nonblocking read sees the value before this edge's write
	always_ff @(posedge iCLK)
	begin
		if (we)
			mem[wAdrs] <= wData;				// Texel load
		rData <= mem[rAdrs];					// Read first order
	end

endmodule

// ==== source/AlphaBlend.sv ====
//-------------------------------------------------
// One register stage, texel weighted by alpha over background
// Alpha 255 gives texel * 255 / 256, never the exact texel
//-------------------------------------------------
`timescale 1ns/1ps

module AlphaBlend
(
	input  logic                  iCLK,
	input  logic                  iRST,
	input  PixelPkg::pixelStreamT bg,			// Background beat
	input  PixelPkg::texelT       tex,			// Texel for the same beat
	output PixelPkg::pixelStreamT dst			// Registered result
);

	//-------------------------------------------------
	// Per channel weighting
	//-------------------------------------------------
	// (bg * (256 - a) + tex * a) >> 8
	function automatic logic [PixelPkg::chanW-1:0] blendChan
	(
		input logic [PixelPkg::chanW-1:0]  bgCh,
		input logic [PixelPkg::chanW-1:0]  texCh,
		input logic [PixelPkg::alphaW-1:0] alpha
	);
		logic [PixelPkg::blendSumW-1:0] bgExt;
		logic [PixelPkg::blendSumW-1:0] texExt;
		logic [PixelPkg::blendSumW-1:0] aExt;
		logic [PixelPkg::blendSumW-1:0] invExt;
		logic [PixelPkg::blendSumW-1:0] sum;
		bgExt  = {{(PixelPkg::blendSumW - PixelPkg::chanW){1'b0}}, bgCh};
		texExt = {{(PixelPkg::blendSumW - PixelPkg::chanW){1'b0}}, texCh};
		aExt   = {{(PixelPkg::blendSumW - PixelPkg::alphaW){1'b0}}, alpha};
		invExt = PixelPkg::alphaOne - aExt;		// Complement weight
		sum    = bgExt * invExt + texExt * aExt;	// Max 63 * 256, no overflow
		return sum[PixelPkg::blendShift +: PixelPkg::chanW];
	endfunction

	// Channels widened to the green width
	logic [PixelPkg::chanW-1:0] bgR;
	logic [PixelPkg::chanW-1:0] bgG;
	logic [PixelPkg::chanW-1:0] bgB;
	logic [PixelPkg::chanW-1:0] txR;
	logic [PixelPkg::chanW-1:0] txG;
	logic [PixelPkg::chanW-1:0] txB;
	logic [PixelPkg::chanW-1:0] mixR;
	logic [PixelPkg::chanW-1:0] mixG;
	logic [PixelPkg::chanW-1:0] mixB;
	PixelPkg::pixelColorT       mix;			// Repacked RGB565

	assign bgR = {{(PixelPkg::chanW - PixelPkg::redW){1'b0}}, bg.color.r};
	assign bgG = bg.color.g;					// Already full width
	assign bgB = {{(PixelPkg::chanW - PixelPkg::blueW){1'b0}}, bg.color.b};
	assign txR = {{(PixelPkg::chanW - PixelPkg::redW){1'b0}}, tex.color.r};
	assign txG = tex.color.g;
	assign txB = {{(PixelPkg::chanW - PixelPkg::blueW){1'b0}}, tex.color.b};

	assign mixR = blendChan(bgR, txR, tex.alpha);
	assign mixG = blendChan(bgG, txG, tex.alpha);
	assign mixB = blendChan(bgB, txB, tex.alpha);

	// Result never exceeds the channel max, upper bits are zero
	always_comb
	begin
		mix.r = mixR[PixelPkg::redW-1:0];
		mix.g = mixG[PixelPkg::greenW-1:0];
		mix.b = mixB[PixelPkg::blueW-1:0];
	end

	//-------------------------------------------------
	// Output stage
	//-------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		dst.color <= mix;
		dst.pos   <= bg.pos;						// Sideband rides along
		if (iRST)
		begin
			dst.valid <= 1'b0;
			dst.frame <= 1'b0;
		end
		else
		begin
			dst.valid <= bg.valid;
			dst.frame <= bg.frame;
		end
	end

endmodule

// ==== source/PlayerDraw.sv ====
//-------------------------------------------------
// Every src beat reaches dst two clocks later, no back-pressure
// Sprite is not clipped, every valid pixel gets a texel
//-------------------------------------------------
`timescale 1ns/1ps

module PlayerDraw
(
	input  logic                  iCLK,
	input  logic                  iRST,
	input  PixelPkg::pixelStreamT src,
	input  BusPkg::busWriteT      bus,			// Texture loads
	input  PixelPkg::playerDirT   dir,			// Sampled with each pixel
	output PixelPkg::pixelStreamT dst
);

	//-------------------------------------------------
	// Bus write decode
	//-------------------------------------------------
	logic                        texWe;
	logic [BusPkg::texAdrsW-1:0] texWAdrs;

	// Strobe and region match, other regions dropped
	assign texWe = bus.we
		&& (bus.adrs[BusPkg::busAdrsW-1:BusPkg::regionLo] == BusPkg::texRegion);
	assign texWAdrs = bus.adrs[BusPkg::texAdrsW-1:0];	// Low bits pick the texel

	//-------------------------------------------------
	// Pixel index and read address
	//-------------------------------------------------
	logic [BusPkg::pixIdxW-1:0]  pixIdx;			// Valid pixels so far this frame
	logic [BusPkg::pixIdxW-1:0]  rdIdx;
	logic [BusPkg::bankW-1:0]    bank;
	logic [BusPkg::texAdrsW-1:0] texRAdrs;

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			pixIdx <= '0;
		else if (!src.frame)
			pixIdx <= '0;						// Restart between frames
		else if (src.valid)
			pixIdx <= pixIdx + 1'b1;				// Wraps at 256
	end

	// Outside a frame the index is 0 in the same cycle
	assign rdIdx    = src.frame ? pixIdx : '0;
	assign bank     = dir;						// Direction picks the bank
	assign texRAdrs = {bank, rdIdx};				// bank * 256 + index

	//-------------------------------------------------
	// Texture RAM
	//-------------------------------------------------
	PixelPkg::texelT texel;						// Valid one clock after texRAdrs

	TextureRam texRam
	(
		.iCLK  (iCLK),
		.we    (texWe),
		.wAdrs (texWAdrs),
		.wData (bus.data),
		.rAdrs (texRAdrs),
		.rData (texel)
	);

	//-------------------------------------------------
	// Align background with RAM latency
	//-------------------------------------------------
	PixelPkg::pixelStreamT srcDly;

	always_ff @(posedge iCLK)
	begin
		srcDly.color <= src.color;
		srcDly.pos   <= src.pos;
		if (iRST)
		begin
			srcDly.valid <= 1'b0;
			srcDly.frame <= 1'b0;
		end
		else
		begin
			srcDly.valid <= src.valid;				// Gaps pass through too
			srcDly.frame <= src.frame;
		end
	end

	// Second clock of latency
	AlphaBlend blend
	(
		.iCLK (iCLK),
		.iRST (iRST),
		.bg   (srcDly),
		.tex  (texel),
		.dst  (dst)
	);

endmodule

// ==== source/DrawTop.sv ====
//-------------------------------------------------
// Two clock latency from src to dst, texture loaded only over bus
//-------------------------------------------------
`timescale 1ns/1ps

module DrawTop
(
	input  logic                  iCLK,
	input  logic                  iRST,			// Synchronous, active high
	// Raster stream in
	input  PixelPkg::pixelStreamT src,
	// Texture write port
	input  BusPkg::busWriteT      bus,
	// Player state
	input  PixelPkg::playerDirT   dir,
	// Raster stream out
	output PixelPkg::pixelStreamT dst
);

	//-------------------------------------------------
	// Sprite overlay stage
	//-------------------------------------------------
	PlayerDraw player
	(
		.iCLK (iCLK),
		.iRST (iRST),
		.src  (src),
		.bus  (bus),
		.dir  (dir),
		.dst  (dst)
	);

endmodule

// ==== dv/ClockGen.sv ====
//-------------------------------------------------
// 4 ns clock, reset high for the first 5 rising edges
//-------------------------------------------------
`timescale 1ns/1ps

module ClockGen
(
	output logic iCLK,
	output logic iRST
);

	localparam int halfPeriod = 2;				// 4 ns period
	localparam int rstCycles  = 5;

	initial
	begin
		iCLK = 1'b0;
		forever #halfPeriod iCLK = ~iCLK;
	end

	// Released on an edge, same as the stimulus
	initial
	begin
		iRST = 1'b1;
		repeat (rstCycles) @(posedge iCLK);
		iRST <= 1'b0;
	end

endmodule

// ==== dv/DrawChecker.sv ====
//-------------------------------------------------
// Expects every texel loaded over the bus before the first frame
// Samples all ports on the rising edge, before the DUT updates
//-------------------------------------------------
`timescale 1ns/1ps

module DrawChecker
(
	input  logic                  iCLK,
	input  logic                  iRST,
	input  PixelPkg::pixelStreamT src,
	input  BusPkg::busWriteT      bus,
	input  PixelPkg::playerDirT   dir,
	input  PixelPkg::pixelStreamT dst,
	output int                    valueErrs,	// Wrong colour or position
	output int                    otherErrs,	// Timing and ordering faults
	output int                    checked,		// Valid dst beats compared
	output int                    pending		// Expected beats still queued
);

	//-------------------------------------------------
	// Model state
	//-------------------------------------------------
	PixelPkg::texelT       shadow [1024];			// Copy of texture contents
	PixelPkg::pixelStreamT expQ [$];				// Expected dst beats in order
	logic [7:0]            idx;					// Valid pixels this frame
	logic [1:0]            frameHist;				// Bit 1 is two edges old
	logic [1:0]            validHist;

	// Per channel (bg * (256 - a) + tex * a) >> 8
	function automatic PixelPkg::pixelColorT blendRef
	(
		input PixelPkg::pixelColorT bg,
		input PixelPkg::texelT      t
	);
		PixelPkg::pixelColorT c;
		int a;
		int inv;
		a   = int'(t.alpha);
		inv = 256 - a;
		c.r = 5'((int'(bg.r) * inv + int'(t.color.r) * a) >> 8);
		c.g = 6'((int'(bg.g) * inv + int'(t.color.g) * a) >> 8);
		c.b = 5'((int'(bg.b) * inv + int'(t.color.b) * a) >> 8);
		return c;
	endfunction

	//-------------------------------------------------
	// Compare and predict
	//-------------------------------------------------
	always @(posedge iCLK)
	begin : watch
		PixelPkg::pixelStreamT expBeat;
		logic [7:0]            useIdx;
		if (iRST)
		begin
			idx       = 8'd0;
			frameHist = 2'b00;
			validHist = 2'b00;
			valueErrs = 0;
			otherErrs = 0;
			checked   = 0;
			expQ.delete();
		end
		else
		begin
			// Two clock latency on the control bits
			if (dst.frame !== frameHist[1])
			begin
				otherErrs++;
				$display("Frame bit on dst is not the src frame bit two cycles earlier, %0t", $time);
			end
			if (dst.valid !== validHist[1])
			begin
				otherErrs++;
				$display("Valid on dst is not the src valid two cycles earlier, %0t", $time);
			end
			frameHist = {frameHist[0], src.frame};
			validHist = {validHist[0], src.valid};

			if (dst.valid === 1'b1)
			begin
				if (expQ.size() == 0)
				begin
					otherErrs++;
					$display("A valid pixel left the DUT with none expected, %0t", $time);
				end
				else
				begin
					expBeat = expQ.pop_front();
					checked++;
					if (dst.color !== expBeat.color)
					begin
						valueErrs++;
						$display("Fail dst.color expected %h got %h at %0t",
							expBeat.color, dst.color, $time);
					end
					if (dst.pos !== expBeat.pos)
					begin
						valueErrs++;
						$display("Fail dst.pos expected %h got %h at %0t",
							expBeat.pos, dst.pos, $time);
					end
				end
			end

			// Texel address is bank * 256 plus index, index 0 outside a frame
			useIdx = src.frame ? idx : 8'd0;
			if (src.valid)
			begin
				expBeat       = src;
				expBeat.color = blendRef(src.color, shadow[{dir, useIdx}]);
				expQ.push_back(expBeat);
			end
			if (!src.frame)
				idx = 8'd0;
			else if (src.valid)
				idx = idx + 8'd1;				// Wraps at 256

			// Write after the read, old data wins on a clash
			if (bus.we && bus.adrs[31:24] == 8'h01)	// Texture region only
				shadow[bus.adrs[9:0]] = bus.data;
		end
		pending = expQ.size();
	end

endmodule

// ==== dv/DrawTb.sv ====
//-------------------------------------------------
// Loads the full texture, then runs six frames with stray writes between
// Fixed seed, watchdog sized from the frame lengths
//-------------------------------------------------
`timescale 1ns/1ps

module DrawTb;

	localparam int pixTotal   = 300 + 200 + 100 + 280 + 240 + 260;	// Valid pixels, all frames
	localparam int strayCount = 64;
	localparam int stimCycles = 20 + 1024 + strayCount + 3 * pixTotal + 6 * 8;	// Gaps up to 2
	localparam int margin     = 200;

	logic                  iCLK;
	logic                  iRST;
	PixelPkg::pixelStreamT src;
	PixelPkg::pixelStreamT dst;
	BusPkg::busWriteT      bus;
	PixelPkg::playerDirT   dir;
	int                    valueErrs;
	int                    otherErrs;
	int                    checked;
	int                    pending;

	ClockGen clkGen
	(
		.iCLK (iCLK),
		.iRST (iRST)
	);

	DrawTop dut
	(
		.iCLK (iCLK),
		.iRST (iRST),
		.src  (src),
		.bus  (bus),
		.dir  (dir),
		.dst  (dst)
	);

	DrawChecker chk
	(
		.iCLK      (iCLK),
		.iRST      (iRST),
		.src       (src),
		.bus       (bus),
		.dir       (dir),
		.dst       (dst),
		.valueErrs (valueErrs),
		.otherErrs (otherErrs),
		.checked   (checked),
		.pending   (pending)
	);

	//-------------------------------------------------
	// Stimulus helpers
	//-------------------------------------------------
	function automatic PixelPkg::pixelStreamT randBeat(input logic valid, input logic frame);
		PixelPkg::pixelStreamT b;
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		r0      = $urandom();
		r1      = $urandom();
		r2      = $urandom();
		b.color = r0[15:0];
		b.valid = valid;
		b.frame = frame;
		b.pos   = {r1, r2[11:0]};				// Random sideband, must pass untouched
		return b;
	endfunction

	task automatic driveBeat(input PixelPkg::pixelStreamT beat, input PixelPkg::playerDirT d);
		@(posedge iCLK);
		src <= beat;
		dir <= d;
	endtask

	// Bits 23:10 random, only 31:24 and 9:0 matter
	task automatic writeBus
	(
		input logic            we,
		input logic [7:0]      region,
		input logic [9:0]      adrs,
		input PixelPkg::texelT data
	);
		BusPkg::busWriteT w;
		logic [31:0] r;
		r      = $urandom();
		w.we   = we;
		w.adrs = {region, r[13:0], adrs};
		w.data = data;
		@(posedge iCLK);
		bus <= w;
	endtask

	// Bank 0 alternates alpha 0 and 255, bank 3 opaque, banks 1 and 2 random
	task automatic loadTexture;
		int i;
		logic [31:0] r;
		logic [9:0] a;
		PixelPkg::texelT t;
		for (i = 0; i < 1024; i++)
		begin
			r       = $urandom();
			a       = 10'(i);
			t.color = r[15:0];
			case (a[9:8])
				2'd0:    t.alpha = a[0] ? 8'hFF : 8'h00;
				2'd3:    t.alpha = 8'hFF;
				default: t.alpha = r[23:16];
			endcase
			writeBus(1'b1, 8'h01, a, t);
		end
		@(posedge iCLK);
		bus.we <= 1'b0;
	endtask

	// Strobe low or foreign region, none may land
	task automatic strayWrites(input int n);
		int i;
		logic [31:0] r;
		logic [31:0] r2;
		logic [7:0] region;
		PixelPkg::texelT t;
		for (i = 0; i < n; i++)
		begin
			r      = $urandom();
			r2     = $urandom();
			t      = r2[23:0];
			region = r[31:24];
			if (region == 8'h01)
				region = 8'h00;
			if (r[0])
				writeBus(1'b0, 8'h01, r[10:1], t);	// Right region, no strobe
			else
				writeBus(1'b1, region, r[10:1], t);
		end
		@(posedge iCLK);
		bus.we <= 1'b0;
	endtask

	// Two lead beats, pixels with optional gaps, three idle beats after
	task automatic runFrame
	(
		input int                  nPix,
		input PixelPkg::playerDirT startDir,
		input logic                gaps,
		input logic                dirWalk			// Change dir inside the frame
	);
		int i;
		logic [31:0] r;
		PixelPkg::playerDirT d;
		d = startDir;
		repeat (2) driveBeat(randBeat(1'b0, 1'b1), d);
		for (i = 0; i < nPix; i++)
		begin
			r = $urandom();
			if (dirWalk && r[4:3] == 2'd0)
				d = r[1:0];
			if (gaps && r[7:6] == 2'd0)
				repeat (1 + int'(r[8])) driveBeat(randBeat(1'b0, 1'b1), d);
			driveBeat(randBeat(1'b1, 1'b1), d);
		end
		repeat (3) driveBeat('0, d);
	endtask

	//-------------------------------------------------
	// Test sequence
	//-------------------------------------------------
	initial
	begin : main
		void'($urandom(48317));
		src = '0;
		bus = '0;
		dir = '0;
		@(posedge iCLK);
		while (iRST)
			@(posedge iCLK);
		repeat (8) driveBeat('0, 2'd0);			// dst must stay idle
		loadTexture();
		runFrame(300, 2'd0, 1'b0, 1'b0);		// Alpha 0 and 255, wraps past 256
		runFrame(200, 2'd1, 1'b1, 1'b0);
		runFrame(100, 2'd2, 1'b0, 1'b0);		// Back to back
		runFrame(280, 2'd3, 1'b1, 1'b0);		// Opaque bank, wraps
		runFrame(240, 2'd0, 1'b1, 1'b1);
		strayWrites(strayCount);
		runFrame(260, 2'd2, 1'b1, 1'b1);		// Reads back over stray addresses
		repeat (6) @(posedge iCLK);				// Drain two stage pipe
		$display("Errors: value %0d, other %0d, pixels checked %0d of %0d, left queued %0d",
			valueErrs, otherErrs, checked, pixTotal, pending);
		if (checked != pixTotal || pending != 0)
			$display("Not every driven pixel came out of the DUT");
		if (valueErrs == 0 && otherErrs == 0 && pending == 0 && checked == pixTotal)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	//-------------------------------------------------
	// Watchdog
	//-------------------------------------------------
	initial
	begin : watchdog
		#((stimCycles + margin) * 4);
		$display("Watchdog expired before the test sequence finished");
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== sim.f ====
source/PixelPkg.sv
source/BusPkg.sv
source/TextureRam.sv
source/AlphaBlend.sv
source/PlayerDraw.sv
source/DrawTop.sv
dv/ClockGen.sv
dv/DrawChecker.sv
dv/DrawTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the sprite overlay testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module DrawTb -o DrawTb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/DrawTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
	exit 0
fi
exit 1
